// File: bench/scope_tb_tests.svh
// directed tests: registers, decimation, edge trigger,
// software and external trigger captures

task automatic test_regs();
  reg_addr_e   ra[$];
  logic [31:0] val[$];
  int          e0;
  e0 = errors;
  ra = '{ra_ctl, ra_mode, ra_trg_sel, ra_pre, ra_pst, ra_sts_pre, ra_sts_pst,
         ra_acq_lo, ra_acq_hi, ra_trg_lo, ra_trg_hi, ra_pos, ra_neg, ra_edg,
         ra_dec, ra_shr, ra_avg};
  foreach (ra[i]) read_expect(ra[i], 32'd0, $sformatf("reset reg 0x%02h", ra[i]));
  ra  = '{ra_mode, ra_trg_sel, ra_pre, ra_pst, ra_pos, ra_neg, ra_edg,
          ra_dec, ra_shr, ra_avg};
  val = '{32'h3, 32'ha, 32'h1234_5678, 32'h0bad_cafe, 32'h0000_7000,
          32'hffff_8100, 32'h1, 32'h1_0005, 32'hb, 32'h1};  // neg one sign extended
  foreach (ra[i]) bus_write(ra[i], val[i]);
  foreach (ra[i]) read_expect(ra[i], val[i], $sformatf("reg 0x%02h", ra[i]));
  finish_test("regs", e0);
endtask

// groups of four, last sample or averaged sum
task automatic check_decimation(input logic avg);
  sample_t in[$];
  sample_t exp;
  int      sum, k, j, e0;
  e0 = errors;
  set_path(17'd4, avg, 4'd2);
  set_capture(32'd0, 4'd0, 32'd0, 32'd0);  // no source, stays armed
  clear_capture();
  restart();
  repeat (32) in.push_back(next_random());
  foreach (in[i]) tx_q.push_back(in[i]);
  wait_rx(8);
  wait_tx_empty();
  if (rx_data.size() != 8) report_value("output sample count", rx_data.size(), 8);
  for (k = 0; k < 8 && k < rx_data.size(); k++) begin
    if (avg) begin
      sum = 0;
      for (j = 0; j < 4; j++) sum += int'(in[4*k+j]);
      exp = sample_t'(sum >>> 2);  // shift, then keep low 16 bits
    end else begin
      exp = in[4*k+3];
    end
    if (rx_data[k] !== exp) report_value($sformatf("sto_data[%0d]", k), rx_data[k], exp);
  end
  bus_write(ra_ctl, 32'h8);  // stop
  finish_test(avg ? "dec_average" : "dec_plain", e0);
endtask

task automatic test_edge();
  int e0;
  e0 = errors;
  set_path(17'd1, 1'b0, 4'd0);
  bus_write(ra_pos, 32'd1000);
  bus_write(ra_neg, 32'hffff_fc18);  // -1000
  bus_write(ra_edg, 32'd0);
  bus_write(ra_ctl, 32'h1);          // disarm
  clear_capture();
  send_ramp(-2000, 2000, 500);       // arms low, fires at 1000
  wait_tx_empty();
  if (trg_out_cnt != 1) report_value("trg_out pulses, rising", trg_out_cnt, 1);
  trg_out_cnt = 0;
  send_ramp(-500, 2000, 500);        // never below lower threshold
  wait_tx_empty();
  if (trg_out_cnt != 0) report_value("trg_out pulses, rising unarmed", trg_out_cnt, 0);
  bus_write(ra_edg, 32'd1);
  bus_write(ra_ctl, 32'h1);
  trg_out_cnt = 0;
  send_ramp(2000, -2000, -500);
  wait_tx_empty();
  if (trg_out_cnt != 1) report_value("trg_out pulses, falling", trg_out_cnt, 1);
  trg_out_cnt = 0;
  send_ramp(500, -2000, -500);       // never above upper threshold
  wait_tx_empty();
  if (trg_out_cnt != 0) report_value("trg_out pulses, falling unarmed", trg_out_cnt, 0);
  finish_test("edge", e0);
endtask

task automatic test_capture_sw();
  logic [31:0] rd, lo, hi;
  logic [63:0] t0, t1, stamp;
  int          n, k, e0;
  e0 = errors;
  set_path(17'd1, 1'b0, 4'd0);
  set_capture(32'd0, 4'b0001, 32'd4, 32'd6);
  clear_capture();
  restart();
  repeat (48) tx_q.push_back(next_random());
  n  = 0;
  rd = '0;
  while (rd != 32'd4 && n < 50) begin  // poll pre count
    bus_read(ra_sts_pre, rd);
    n++;
  end
  if (rd != 32'd4) report_problem("pre-trigger count never reached 4");
  t0 = cts;
  bus_write(ra_ctl, 32'h2);            // software trigger
  wait_irq(1'b0, 1);
  t1 = cts;
  wait_irq(1'b1, 1);
  if (rx_data.size() - post_mark != 6)
    report_value("samples after trigger", rx_data.size() - post_mark, 6);
  for (k = 0; k < rx_data.size(); k++)
    if (rx_last[k] !== (k == rx_data.size() - 1))
      report_value($sformatf("sto_last[%0d]", k), rx_last[k], k == rx_data.size() - 1);
  if (irq_trg_cnt != 1) report_value("irq_trg pulses", irq_trg_cnt, 1);
  read_expect(ra_sts_pre, 32'd4, "sts_pre");
  read_expect(ra_sts_pst, 32'd6, "sts_pst");
  read_expect(ra_ctl, 32'h2, "ctl status");  // trigger seen, not active
  bus_read(ra_trg_lo, lo);
  bus_read(ra_trg_hi, hi);
  stamp = {hi, lo};
  if (stamp < t0 || stamp > t1)
    report_problem($sformatf("trigger stamp %0d outside %0d..%0d", stamp, t0, t1));
  wait_tx_empty();
  finish_test("capture_sw", e0);
endtask

task automatic test_capture_ext();
  int e0;
  e0 = errors;
  set_path(17'd1, 1'b0, 4'd0);
  set_capture(32'd0, 4'b1000, 32'd0, 32'd3);  // ext1 only
  clear_capture();
  restart();
  repeat (40) tx_q.push_back(next_random());
  read_expect(ra_ctl, 32'h4, "ctl status, armed");
  pulse_ext(2'b01);
  repeat (8) @(negedge bus);
  if (irq_trg_cnt != 0) report_value("irq_trg after ext0", irq_trg_cnt, 0);
  pulse_ext(2'b10);
  wait_irq(1'b0, 1);
  wait_irq(1'b1, 1);
  clear_capture();
  bus_write(ra_ctl, 32'h4);            // start again, then abort
  read_expect(ra_ctl, 32'h4, "ctl status, started");
  bus_write(ra_ctl, 32'h8);
  read_expect(ra_ctl, 32'h0, "ctl status, stopped");
  repeat (8) tx_q.push_back(next_random());
  pulse_ext(2'b10);                    // would capture if still armed
  repeat (24) @(negedge bus);
  if (irq_trg_cnt != 0) report_value("irq_trg after stop", irq_trg_cnt, 0);
  if (irq_stp_cnt != 0) report_value("irq_stp after stop", irq_stp_cnt, 0);
  wait_tx_empty();
  finish_test("capture_ext", e0);
endtask

// File: bench/scope_tb.sv
// scope testbench: clock, reset, DUT, bus and stream helpers,
// output monitor and test sequence
`timescale 1ns/1ps

module scope_tb;
  import scope_pkg::*;

  logic           bus;
  logic           rst_n;
  logic [baw-1:0] sys_addr;
  logic [31:0]    sys_wdata;
  logic           sys_wen, sys_ren;
  logic [31:0]    sys_rdata;
  logic           sys_ack;
  logic [tw-1:0]  cts;
  sample_t        adc_data;
  logic           adc_valid;
  logic [1:0]     trg_ext;
  logic           trg_out;
  sample_t        sto_data;
  logic           sto_valid, sto_last, irq_trg, irq_stp;

  sample_t        tx_q[$];     // samples waiting for the sender
  logic           tx_phase;
  sample_t        rx_data[$];  // captured output stream
  logic           rx_last[$];
  int             post_mark;   // rx size when irq_trg seen
  int             trg_out_cnt, irq_trg_cnt, irq_stp_cnt;
  int             errors, tests;
  logic [31:0]    lcg_state;

  scope_top i_scope_top (.*);

  always #5 bus = ~bus;

  always @(posedge bus) cts <= cts + 64'd1;  // free-running time

  // sender, at most one sample every two cycles
  always @(posedge bus) begin
    tx_phase <= ~tx_phase;
    if (tx_phase && tx_q.size() != 0) begin
      adc_data  <= tx_q.pop_front();
      adc_valid <= 1'b1;
    end else begin
      adc_valid <= 1'b0;
    end
  end

  // output monitor, stands in for the sample buffer
  always @(posedge bus) begin
    if (sto_valid) begin
      rx_data.push_back(sto_data);
      rx_last.push_back(sto_last);
    end
    if (irq_trg) begin
      irq_trg_cnt++;
      post_mark = rx_data.size();  // later samples are post-trigger
    end
    if (irq_stp) irq_stp_cnt++;
    if (trg_out) trg_out_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic sample_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return sample_t'(lcg_state[31:16]);  // upper bits, better spread
  endfunction

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("%0t ns  %-14s done, %0d errors", $time, name, errors - err_before);
  endtask

  task automatic wait_ack();
    int lat;
    lat = 1;
    @(negedge bus);
    while (!sys_ack && lat < 16) begin
      @(negedge bus);
      lat++;
    end
    if (!sys_ack) report_problem("timeout waiting for sys_ack");
    else if (lat != 1) report_value("sys_ack latency", 64'(lat), 64'd1);
  endtask

  task automatic bus_write(input logic [baw-1:0] addr, input logic [31:0] data);
    @(posedge bus);
    sys_addr  <= addr;
    sys_wdata <= data;
    sys_wen   <= 1'b1;
    @(posedge bus);  // write lands here
    sys_wen <= 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input logic [baw-1:0] addr, output logic [31:0] data);
    @(posedge bus);
    sys_addr <= addr;
    sys_ren  <= 1'b1;
    @(posedge bus);
    sys_ren <= 1'b0;
    wait_ack();
    data = sys_rdata;  // valid with ack
  endtask

  task automatic read_expect(input logic [baw-1:0] addr, input logic [31:0] exp,
                             input string name);
    logic [31:0] rd;
    bus_read(addr, rd);
    if (rd !== exp) report_value(name, rd, exp);
  endtask

  task automatic wait_tx_empty();
    int n;
    n = 0;
    while (tx_q.size() != 0 && n < 2000) begin
      @(negedge bus);
      n++;
    end
    if (tx_q.size() != 0) begin
      report_problem("sample queue never drained");
      tx_q.delete();
    end
    repeat (4) @(negedge bus);  // dec, edge and acq stages
  endtask

  task automatic wait_rx(input int cnt);
    int n;
    n = 0;
    while (rx_data.size() < cnt && n < 1000) begin
      @(negedge bus);
      n++;
    end
    if (rx_data.size() < cnt) report_problem("timeout waiting for output samples");
  endtask

  task automatic wait_irq(input logic stp, input int cnt);
    int n;
    n = 0;
    while ((stp ? irq_stp_cnt : irq_trg_cnt) < cnt && n < 1000) begin
      @(negedge bus);
      n++;
    end
    if ((stp ? irq_stp_cnt : irq_trg_cnt) < cnt)
      report_problem(stp ? "timeout waiting for irq_stp" : "timeout waiting for irq_trg");
  endtask

  task automatic clear_capture();
    rx_data.delete();
    rx_last.delete();
    post_mark   = 0;
    trg_out_cnt = 0;
    irq_trg_cnt = 0;
    irq_stp_cnt = 0;
  endtask

  task automatic set_path(input logic [dcw-1:0] dec, input logic avg,
                          input logic [dsw-1:0] shr);
    bus_write(ra_dec, 32'(dec));
    bus_write(ra_avg, 32'(avg));
    bus_write(ra_shr, 32'(shr));
  endtask

  task automatic set_capture(input logic [31:0] mode, input logic [tn-1:0] sel,
                             input logic [31:0] pre, input logic [31:0] pst);
    bus_write(ra_mode, mode);
    bus_write(ra_trg_sel, 32'(sel));
    bus_write(ra_pre, pre);
    bus_write(ra_pst, pst);
  endtask

  task automatic restart();
    bus_write(ra_ctl, 32'h1);  // clear data path state
    bus_write(ra_ctl, 32'h4);  // start
  endtask

  task automatic send_ramp(input int from, input int to, input int step);
    int v;
    v = from;
    while ((step > 0) ? (v <= to) : (v >= to)) begin
      tx_q.push_back(sample_t'(v));
      v += step;
    end
  endtask

  task automatic pulse_ext(input logic [1:0] v);
    @(posedge bus);
    trg_ext <= v;
    @(posedge bus);
    trg_ext <= 2'b00;
  endtask

  `include "scope_tb_tests.svh"

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bus       = 1'b0;
    rst_n     = 1'b0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    cts       = '0;
    adc_data  = '0;
    adc_valid = 1'b0;
    trg_ext   = 2'b00;
    tx_phase  = 1'b0;
    lcg_state = 32'hebef;
    errors    = 0;
    tests     = 0;
    clear_capture();
    repeat (8) @(posedge bus);
    rst_n <= 1'b1;
    @(posedge bus);
    test_regs();
    check_decimation(1'b0);
    check_decimation(1'b1);
    test_edge();
    test_capture_sw();
    test_capture_ext();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: hdl/scope_acq.sv
// acquisition FSM: pre/post counters, trigger select, stamps, irqs
`timescale 1ns/1ps

module scope_acq (
  input  logic                     bus,
  input  logic                     rst_n,
  scope_cfg_if.acq                 cfg,
  input  logic [scope_pkg::tw-1:0] cts,
  input  scope_pkg::sample_t       sti_data,
  input  logic                     sti_valid,
  input  logic                     trg_edge,
  input  logic [1:0]               trg_ext,
  output scope_pkg::sample_t       sto_data,
  output logic                     sto_valid,
  output logic                     sto_last,
  output logic                     irq_trg,
  output logic                     irq_stp
);
  import scope_pkg::*;

  acq_state_e    state;
  logic [tn-1:0] src;       // sw, edge, ext0, ext1
  logic          trg_hit;
  logic          pst_done;  // current sample is the final post sample

  assign src         = {trg_ext, trg_edge, cfg.ctl_swt};
  assign trg_hit     = cfg.cfg_aut || (|(src & cfg.cfg_trg));
  assign pst_done    = (cfg.sts_pst + cw'(1)) >= cfg.cfg_pst;
  assign cfg.sts_acq = (state != st_idle);

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      cfg.sts_pre <= '0;
      cfg.sts_pst <= '0;
      cfg.sts_trg <= 1'b0;
      cfg.cts_acq <= '0;
      cfg.cts_trg <= '0;
      sto_valid   <= 1'b0;
      sto_last    <= 1'b0;
      irq_trg     <= 1'b0;
      irq_stp     <= 1'b0;
    end else begin
      irq_trg   <= 1'b0;
      irq_stp   <= 1'b0;
      sto_last  <= 1'b0;
      sto_valid <= sti_valid && (state != st_idle);  // forward while active
      if (cfg.ctl_rst) begin
        state       <= st_idle;
        cfg.sts_pre <= '0;
        cfg.sts_pst <= '0;
        cfg.sts_trg <= 1'b0;
      end else if (cfg.ctl_stp) begin
        state <= st_idle;            // abort, no irq
      end else begin
        case (state)
          st_idle: if (cfg.ctl_acq) begin
            state       <= st_pre;
            cfg.cts_acq <= cts;
            cfg.sts_pre <= '0;
            cfg.sts_pst <= '0;
            cfg.sts_trg <= 1'b0;
          end
          st_pre: begin
            if (cfg.sts_pre >= cfg.cfg_pre) state <= st_arm;
            else if (sti_valid) cfg.sts_pre <= cfg.sts_pre + cw'(1);
          end
          st_arm: if (trg_hit) begin
            state       <= st_post;
            cfg.cts_trg <= cts;
            cfg.sts_trg <= 1'b1;
            irq_trg     <= 1'b1;
          end
          st_post: if (sti_valid) begin
            cfg.sts_pst <= cfg.sts_pst + cw'(1);
            if (pst_done) begin
              sto_last <= 1'b1;      // marks this forwarded sample
              irq_stp  <= 1'b1;
              if (cfg.cfg_con) begin // rearm for next capture
                state       <= st_pre;
                cfg.sts_pre <= '0;
                cfg.sts_pst <= '0;
              end else begin
                state <= st_idle;
              end
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  always_ff @(posedge bus) begin
    sto_data <= sti_data;
  end

  a_last_valid: assert property (@(posedge bus) disable iff (!rst_n)
    sto_last |-> sto_valid);
  a_irq_idle: assert property (@(posedge bus) disable iff (!rst_n)
    irq_trg |-> (state != st_idle));

endmodule

// File: hdl/scope_cfg_if.sv
// configuration, control strobes and status between
// the register block and the data path
`timescale 1ns/1ps

interface scope_cfg_if;
  import scope_pkg::*;

  // decimator
  logic [dcw-1:0] cfg_dec;  // factor, 0 acts as 1
  logic [dsw-1:0] cfg_shr;
  logic           cfg_avg;
  // edge detector
  sample_t        cfg_pos;  // upper threshold
  sample_t        cfg_neg;  // lower threshold
  logic           cfg_edg;  // 0 rising, 1 falling
  // acquisition
  logic           cfg_con;  // continuous
  logic           cfg_aut;  // automatic trigger
  logic [tn-1:0]  cfg_trg;  // source enables
  logic [cw-1:0]  cfg_pre;
  logic [cw-1:0]  cfg_pst;
  // one-cycle strobes
  logic           ctl_rst, ctl_acq, ctl_stp, ctl_swt;
  // status back to registers
  logic           sts_acq, sts_trg;
  logic [cw-1:0]  sts_pre, sts_pst;
  logic [tw-1:0]  cts_acq, cts_trg;

  modport regs (
    output cfg_dec, cfg_shr, cfg_avg, cfg_pos, cfg_neg, cfg_edg,
    output cfg_con, cfg_aut, cfg_trg, cfg_pre, cfg_pst,
    output ctl_rst, ctl_acq, ctl_stp, ctl_swt,
    input  sts_acq, sts_trg, sts_pre, sts_pst, cts_acq, cts_trg
  );
  modport dec (input cfg_dec, cfg_shr, cfg_avg, ctl_rst);
  modport edg (input cfg_pos, cfg_neg, cfg_edg, ctl_rst);  // "edge" is a keyword
  modport acq (
    input  cfg_con, cfg_aut, cfg_trg, cfg_pre, cfg_pst,
    input  ctl_rst, ctl_acq, ctl_stp, ctl_swt,
    output sts_acq, sts_trg, sts_pre, sts_pst, cts_acq, cts_trg
  );

endinterface

// File: hdl/scope_dec_avg.sv
// decimator, last sample of each group or shifted group sum
`timescale 1ns/1ps

module scope_dec_avg (
  input  logic               bus,
  input  logic               rst_n,
  scope_cfg_if.dec           cfg,
  input  scope_pkg::sample_t sti_data,
  input  logic               sti_valid,
  output scope_pkg::sample_t sto_data,
  output logic               sto_valid
);
  import scope_pkg::*;

  logic [dcw-1:0]           cnt;      // samples so far in group
  logic signed [dw+dcw-1:0] sum;      // running group sum
  logic signed [dw+dcw-1:0] sum_nxt;  // sum including current sample
  logic signed [dw+dcw-1:0] sum_shr;
  logic                     last;     // current sample closes group

  assign sum_nxt = sum + sti_data;           // sign extended
  assign sum_shr = sum_nxt >>> cfg.cfg_shr;
  // factor 0 or 1 passes every sample
  assign last = (cfg.cfg_dec <= dcw'(1)) || (cnt >= cfg.cfg_dec - dcw'(1));

  ////////////////////////////////////////////////////////////
  // group counter and accumulator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      sum       <= '0;
      sto_valid <= 1'b0;
    end else if (cfg.ctl_rst) begin
      cnt       <= '0;
      sum       <= '0;
      sto_valid <= 1'b0;
    end else begin
      sto_valid <= sti_valid & last;
      if (sti_valid) begin
        if (last) begin
          cnt <= '0;
          sum <= '0;
        end else begin
          cnt <= cnt + dcw'(1);
          sum <= sum_nxt;
        end
      end
    end
  end

  // output sample, payload only
  always_ff @(posedge bus) begin
    if (sti_valid && last) begin
      sto_data <= cfg.cfg_avg ? sum_shr[dw-1:0] : sti_data;  // truncated average
    end
  end

  // groups of two or more never give back-to-back outputs
  a_dec_gap: assert property (@(posedge bus) disable iff (!rst_n)
    (sto_valid && cfg.cfg_dec > dcw'(1) && $stable(cfg.cfg_dec)) |=> !sto_valid);

endmodule

// File: hdl/scope_edge.sv
// hysteresis edge detector, analog trigger plus delayed stream
`timescale 1ns/1ps

module scope_edge (
  input  logic               bus,
  input  logic               rst_n,
  scope_cfg_if.edg           cfg,
  input  scope_pkg::sample_t sti_data,
  input  logic               sti_valid,
  output scope_pkg::sample_t sto_data,
  output logic               sto_valid,
  output logic               trg
);
  import scope_pkg::*;

  logic armed;
  logic arm_hit;   // sample on the arming side
  logic fire_hit;  // sample past the firing level

  always_comb begin
    if (cfg.cfg_edg) begin  // falling
      arm_hit  = sti_data > cfg.cfg_pos;
      fire_hit = sti_data <= cfg.cfg_neg;
    end else begin          // rising
      arm_hit  = sti_data < cfg.cfg_neg;
      fire_hit = sti_data >= cfg.cfg_pos;
    end
  end

  ////////////////////////////////////////////////////////////
  // schmitt state and trigger pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      armed     <= 1'b0;
      trg       <= 1'b0;
      sto_valid <= 1'b0;
    end else begin
      trg       <= 1'b0;
      sto_valid <= sti_valid;        // one cycle delay
      if (cfg.ctl_rst) begin
        armed <= 1'b0;
      end else if (sti_valid) begin
        if (armed && fire_hit) begin
          trg   <= 1'b1;             // aligned with delayed sample
          armed <= 1'b0;
        end else if (arm_hit) begin
          armed <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge bus) begin
    sto_data <= sti_data;
  end

endmodule

// File: hdl/scope_pkg.sv
// shared widths, sample type, register map and acquisition states
// for the scope acquisition subsystem
package scope_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned dw  = 16;  // adc sample
  localparam int unsigned cw  = 32;  // pre/post counters
  localparam int unsigned tw  = 64;  // timestamps
  localparam int unsigned tn  = 4;   // trigger sources: sw, edge, ext0, ext1
  localparam int unsigned dcw = 17;  // decimation factor
  localparam int unsigned dsw = 4;   // average shift
  localparam int unsigned baw = 7;   // decoded bus address

  typedef logic signed [dw-1:0] sample_t;

  // register map, byte addresses
  typedef enum logic [baw-1:0] {
    ra_ctl     = 7'h00,  // wr: rst/swt/start/stop, rd: trg seen, acq active
    ra_mode    = 7'h04,  // continuous, automatic
    ra_trg_sel = 7'h08,
    ra_pre     = 7'h10,
    ra_pst     = 7'h14,
    ra_sts_pre = 7'h18,
    ra_sts_pst = 7'h1c,
    ra_acq_lo  = 7'h20,  // arm stamp
    ra_acq_hi  = 7'h24,
    ra_trg_lo  = 7'h28,  // trigger stamp
    ra_trg_hi  = 7'h2c,
    ra_pos     = 7'h40,  // upper threshold
    ra_neg     = 7'h44,  // lower threshold
    ra_edg     = 7'h48,  // 0 rising, 1 falling
    ra_dec     = 7'h50,
    ra_shr     = 7'h54,
    ra_avg     = 7'h58
  } reg_addr_e;

  typedef enum logic [1:0] {
    st_idle,
    st_pre,   // filling pre-trigger samples
    st_arm,   // waiting for trigger
    st_post   // counting post-trigger samples
  } acq_state_e;

endpackage

// File: hdl/scope_regs.sv
// register block: bus write decode, control strobes, read mux
`timescale 1ns/1ps

module scope_regs (
  input  logic                      bus,
  input  logic                      rst_n,
  input  logic [scope_pkg::baw-1:0] sys_addr,
  input  logic [31:0]               sys_wdata,
  input  logic                      sys_wen,
  input  logic                      sys_ren,
  output logic [31:0]               sys_rdata,
  output logic                      sys_ack,
  scope_cfg_if.regs                 cfg
);
  import scope_pkg::*;

  reg_addr_e addr;
  logic      ctl_wr;  // write to control register

  assign addr   = reg_addr_e'(sys_addr);
  assign ctl_wr = sys_wen && (addr == ra_ctl);

  ////////////////////////////////////////////////////////////
  // ack and control strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      sys_ack     <= 1'b0;
      cfg.ctl_rst <= 1'b0;
      cfg.ctl_swt <= 1'b0;
      cfg.ctl_acq <= 1'b0;
      cfg.ctl_stp <= 1'b0;
    end else begin
      sys_ack     <= sys_wen | sys_ren;     // one cycle after access
      cfg.ctl_rst <= ctl_wr & sys_wdata[0];
      cfg.ctl_swt <= ctl_wr & sys_wdata[1]; // software trigger
      cfg.ctl_acq <= ctl_wr & sys_wdata[2]; // start
      cfg.ctl_stp <= ctl_wr & sys_wdata[3]; // stop
    end
  end

  ////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg.cfg_con <= 1'b0;
      cfg.cfg_aut <= 1'b0;
      cfg.cfg_trg <= '0;
      cfg.cfg_pre <= '0;
      cfg.cfg_pst <= '0;
      cfg.cfg_pos <= '0;
      cfg.cfg_neg <= '0;
      cfg.cfg_edg <= 1'b0;
      cfg.cfg_dec <= '0;
      cfg.cfg_shr <= '0;
      cfg.cfg_avg <= 1'b0;
    end else if (sys_wen) begin
      case (addr)
        ra_mode: begin
          cfg.cfg_con <= sys_wdata[0];
          cfg.cfg_aut <= sys_wdata[1];
        end
        ra_trg_sel: cfg.cfg_trg <= sys_wdata[tn-1:0];
        ra_pre:     cfg.cfg_pre <= sys_wdata[cw-1:0];
        ra_pst:     cfg.cfg_pst <= sys_wdata[cw-1:0];
        ra_pos:     cfg.cfg_pos <= sys_wdata[dw-1:0];
        ra_neg:     cfg.cfg_neg <= sys_wdata[dw-1:0];
        ra_edg:     cfg.cfg_edg <= sys_wdata[0];
        ra_dec:     cfg.cfg_dec <= sys_wdata[dcw-1:0];
        ra_shr:     cfg.cfg_shr <= sys_wdata[dsw-1:0];
        ra_avg:     cfg.cfg_avg <= sys_wdata[0];
        default: ;  // ctl strobes above, status is read only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux, data valid together with ack
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (sys_ren) begin
      case (addr)
        ra_ctl:     sys_rdata <= {29'd0, cfg.sts_acq, cfg.sts_trg, 1'b0};
        ra_mode:    sys_rdata <= {30'd0, cfg.cfg_aut, cfg.cfg_con};
        ra_trg_sel: sys_rdata <= {{(32-tn){1'b0}}, cfg.cfg_trg};
        ra_pre:     sys_rdata <= cfg.cfg_pre;
        ra_pst:     sys_rdata <= cfg.cfg_pst;
        ra_sts_pre: sys_rdata <= cfg.sts_pre;
        ra_sts_pst: sys_rdata <= cfg.sts_pst;
        ra_acq_lo:  sys_rdata <= cfg.cts_acq[31:0];
        ra_acq_hi:  sys_rdata <= cfg.cts_acq[63:32];
        ra_trg_lo:  sys_rdata <= cfg.cts_trg[31:0];
        ra_trg_hi:  sys_rdata <= cfg.cts_trg[63:32];
        ra_pos:     sys_rdata <= {{(32-dw){cfg.cfg_pos[dw-1]}}, cfg.cfg_pos};  // sign ext
        ra_neg:     sys_rdata <= {{(32-dw){cfg.cfg_neg[dw-1]}}, cfg.cfg_neg};
        ra_edg:     sys_rdata <= {31'd0, cfg.cfg_edg};
        ra_dec:     sys_rdata <= {{(32-dcw){1'b0}}, cfg.cfg_dec};
        ra_shr:     sys_rdata <= {{(32-dsw){1'b0}}, cfg.cfg_shr};
        ra_avg:     sys_rdata <= {31'd0, cfg.cfg_avg};
        default:    sys_rdata <= '0;
      endcase
    end
  end

  // ack exactly one cycle after every access, never otherwise
  a_ack: assert property (@(posedge bus) disable iff (!rst_n)
    sys_ack == $past(sys_wen | sys_ren));

endmodule

// File: hdl/scope_top.sv
// scope top level: register block, decimator, edge detector
// and acquisition controller
`timescale 1ns/1ps

module scope_top (
  input  logic                      bus,
  input  logic                      rst_n,
  // register bus
  input  logic [scope_pkg::baw-1:0] sys_addr,
  input  logic [31:0]               sys_wdata,
  input  logic                      sys_wen,
  input  logic                      sys_ren,
  output logic [31:0]               sys_rdata,
  output logic                      sys_ack,
  // time and triggers
  input  logic [scope_pkg::tw-1:0]  cts,
  input  scope_pkg::sample_t        adc_data,
  input  logic                      adc_valid,
  input  logic [1:0]                trg_ext,
  output logic                      trg_out,   // edge trigger
  // captured stream
  output scope_pkg::sample_t        sto_data,
  output logic                      sto_valid,
  output logic                      sto_last,
  output logic                      irq_trg,
  output logic                      irq_stp
);
  import scope_pkg::*;

  sample_t dec_data, edg_data;  // inter-stage streams
  logic    dec_valid, edg_valid;

  scope_cfg_if cfg ();

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  scope_regs i_regs (
    .bus, .rst_n, .sys_addr, .sys_wdata, .sys_wen, .sys_ren,
    .sys_rdata, .sys_ack, .cfg (cfg.regs)
  );

  scope_dec_avg i_dec (
    .bus, .rst_n, .cfg (cfg.dec),
    .sti_data (adc_data), .sti_valid (adc_valid),
    .sto_data (dec_data), .sto_valid (dec_valid)
  );

  ////////////////////////////////////////////////////////////
  // processing and output side
  ////////////////////////////////////////////////////////////

  scope_edge i_edge (
    .bus, .rst_n, .cfg (cfg.edg),
    .sti_data (dec_data), .sti_valid (dec_valid),
    .sto_data (edg_data), .sto_valid (edg_valid),
    .trg      (trg_out)
  );

  scope_acq i_acq (
    .bus, .rst_n, .cfg (cfg.acq), .cts,
    .sti_data (edg_data), .sti_valid (edg_valid),
    .trg_edge (trg_out), .trg_ext,
    .sto_data, .sto_valid, .sto_last, .irq_trg, .irq_stp
  );

endmodule

// File: run.sh
#!/bin/sh
# build and run the scope testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module scope_tb -Mdir obj_dir -o scope_sim
./obj_dir/scope_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

// File: tb.f
+incdir+bench
hdl/scope_pkg.sv
hdl/scope_cfg_if.sv
hdl/scope_regs.sv
hdl/scope_dec_avg.sv
hdl/scope_edge.sv
hdl/scope_acq.sv
hdl/scope_top.sv
bench/scope_tb.sv
